/* gfx_raster.f */
+incdir+include
hw/gfx_pkg.sv
hw/cmd_dispatch.sv
hw/rect_fill_engine.sv
hw/pixel_write_merge.sv
hw/framebuffer_ram.sv
hw/display_timing.sv
hw/scanout_palette.sv
hw/gfx_raster_top.sv
test/gfx_raster_tb.sv

/* include/gfx_tb_model.svh */
//**************************************************
// testbench reference model with framebuffer copy,
// clipped command apply and expected scanout colour
//**************************************************
`ifndef GFX_TB_MODEL_SVH
`define GFX_TB_MODEL_SVH

localparam int REF_PIX = `GFX_FB_W * `GFX_FB_H;

logic [`GFX_CIDX_W-1:0] ref_fb [REF_PIX];  // what memory should hold

task automatic reset_ref_fb();
    for (int i = 0; i < REF_PIX; i++) ref_fb[i] = '0;  // memory powers up as 0
endtask

// clear covers the whole picture and rects clip to 0..W-1 and 0..H-1
task automatic apply_to_model(input draw_cmd_t c);
    int xb, xe, yb, ye;
    if (c.op == OP_CLEAR) begin
        xb = 0;
        yb = 0;
        xe = `GFX_FB_W - 1;
        ye = `GFX_FB_H - 1;
    end else begin
        xb = int'($signed(c.x0));
        yb = int'($signed(c.y0));
        xe = xb + int'(c.w) - 1;  // inclusive end
        ye = yb + int'(c.h) - 1;
        if (xb < 0) xb = 0;
        if (yb < 0) yb = 0;
        if (xe > `GFX_FB_W - 1) xe = `GFX_FB_W - 1;
        if (ye > `GFX_FB_H - 1) ye = `GFX_FB_H - 1;
    end
    for (int y = yb; y <= ye; y++) begin  // empty window skips both loops
        for (int x = xb; x <= xe; x++) ref_fb[y * `GFX_FB_W + x] = c.cidx;
    end
endtask

// colour at a display position with black outside the scaled picture
function automatic rgb_t expected_rgb(input int sx, input int sy);
    int          fx, fy;
    logic [11:0] c;
    rgb_t        e;
    if (sy < `GFX_OFFY || sy >= `GFX_OFFY + `GFX_FB_H * `GFX_SCALE) return '0;
    if (sx < 0 || sx >= `GFX_FB_W * `GFX_SCALE) return '0;
    fx  = sx / `GFX_SCALE;
    fy  = (sy - `GFX_OFFY) / `GFX_SCALE;
    c   = PALETTE[ref_fb[fy * `GFX_FB_W + fx]];
    e.r = 8'(c[11:8] * 17);  // nibble times 17 fills 8 bits
    e.g = 8'(c[7:4] * 17);
    e.b = 8'(c[3:0] * 17);
    return e;
endfunction

`endif

/* test/gfx_raster_tb.sv */
//**************************************************
// testbench for the raster top with command table,
// reference frame compare, lane and stall monitors
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module gfx_raster_tb import gfx_pkg::*; ();

    localparam int NSTEPS     = 6;
    localparam int MAXC       = 12;
    localparam int FRAME_CYC  = `GFX_H_TOTAL * `GFX_V_TOTAL;
    localparam int WAIT_LIMIT = 4000;  // a full clear plus a rect with margin

    logic                          clk_sys;
    logic                          rst_sys;
    draw_cmd_t                     cmd;
    logic                          cmd_valid;
    logic                          cmd_ready, idle;
    logic signed [`GFX_CORD_W-1:0] sdl_sx, sdl_sy;
    logic                          sdl_de, sdl_frame;
    logic [7:0]                    sdl_r, sdl_g, sdl_b;

    // stimulus table
    string     step_name     [NSTEPS];
    int        step_len      [NSTEPS];
    draw_cmd_t step_cmd      [NSTEPS][MAXC];
    int        step_min_busy [NSTEPS];  // lanes busy together or 0 to skip
    int        step_gap_max  [NSTEPS];  // random idle cycles before a command
    bit        step_stall    [NSTEPS];  // cmd_ready must push back

    int accepted, total_sent, max_busy, stall_cycles;

    `include "gfx_tb_model.svh"

    gfx_raster_top u_gfx_raster_top (
        .clk_sys, .rst_sys, .cmd, .cmd_valid, .cmd_ready, .idle,
        .sdl_sx, .sdl_sy, .sdl_de, .sdl_frame, .sdl_r, .sdl_g, .sdl_b
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    // handshakes, stalls and lane overlap sampled mid cycle
    always @(negedge clk_sys) begin
        if (!rst_sys) begin
            if (cmd_valid && cmd_ready)  accepted = accepted + 1;
            if (cmd_valid && !cmd_ready) stall_cycles = stall_cycles + 1;
            if ($countones(u_gfx_raster_top.lane_busy) > max_busy)
                max_busy = $countones(u_gfx_raster_top.lane_busy);
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "check failed");
        end
    endtask

    function automatic draw_cmd_t rect_cmd(input int x0, input int y0, input int w,
                                           input int h, input int c);
        draw_cmd_t r;
        r.op   = OP_FILL_RECT;
        r.x0   = `GFX_CORD_W'(x0);
        r.y0   = `GFX_CORD_W'(y0);
        r.w    = `GFX_CORD_W'(w);
        r.h    = `GFX_CORD_W'(h);
        r.cidx = `GFX_CIDX_W'(c);
        return r;
    endfunction

    function automatic draw_cmd_t clear_cmd(input int c);
        draw_cmd_t r;
        r      = '0;  // dispatch makes the bands from cidx alone
        r.op   = OP_CLEAR;
        r.cidx = `GFX_CIDX_W'(c);
        return r;
    endfunction

    task automatic set_step(input int s, input string name, input int min_busy,
                            input int gap_max, input bit stall);
        step_name[s]     = name;
        step_len[s]      = 0;
        step_min_busy[s] = min_busy;
        step_gap_max[s]  = gap_max;
        step_stall[s]    = stall;
    endtask

    task automatic add_cmd(input int s, input draw_cmd_t c);
        step_cmd[s][step_len[s]] = c;
        step_len[s]++;
    endtask

    task automatic build_table();
        set_step(0, "reset_state", 0, 0, 1'b0);
        set_step(1, "clear_all", `GFX_LANES, 0, 1'b0);
        add_cmd(1, clear_cmd(3));
        set_step(2, "parallel_rects", 2, 0, 1'b0);    // back to back
        add_cmd(2, rect_cmd(1, 1, 6, 5, 2));
        add_cmd(2, rect_cmd(10, 2, 8, 4, 4));
        add_cmd(2, rect_cmd(20, 10, 5, 6, 5));
        add_cmd(2, rect_cmd(2, 14, 9, 7, 9));
        set_step(3, "clipped_rects", 0, 2, 1'b0);
        add_cmd(3, rect_cmd(-3, -2, 6, 5, 6));        // top left corner
        add_cmd(3, rect_cmd(28, 20, 10, 10, 7));      // bottom right corner
        add_cmd(3, rect_cmd(-5, 10, 40, 2, 10));      // both sides
        add_cmd(3, rect_cmd(40, 5, 4, 4, 1));         // right of picture
        add_cmd(3, rect_cmd(5, -20, 3, 4, 12));       // above picture
        add_cmd(3, rect_cmd(-60, 3, 20, 2, 13));      // left of picture
        set_step(4, "clear_then_rects", 0, 2, 1'b0);
        add_cmd(4, rect_cmd(0, 0, 10, 10, 11));
        add_cmd(4, clear_cmd(8));
        add_cmd(4, rect_cmd(4, 4, 6, 6, 13));
        add_cmd(4, rect_cmd(15, 8, 10, 3, 14));
        set_step(5, "burst", 2, 3, 1'b1);
        add_cmd(5, clear_cmd(1));
        for (int k = 0; k < 9; k++) begin             // non-overlapping 8x8 grid cells
            add_cmd(5, rect_cmd((k % 4) * 8, (k / 4) * 8, 7, 7, k + 2));
        end
    endtask

    // enter on a rising edge, leave on the transfer edge
    task automatic send_cmd(input draw_cmd_t c, input int gap);
        int n;
        if (gap > 0) begin
            cmd_valid <= 1'b0;
            repeat (gap) @(posedge clk_sys);
        end
        cmd       <= c;
        cmd_valid <= 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (!cmd_ready) begin
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout waiting for cmd_ready");
            @(negedge clk_sys);
        end
        @(posedge clk_sys);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk_sys);
        while (!idle) begin
            n++;
            if (n > WAIT_LIMIT) fail_run("timeout waiting for idle");
            @(negedge clk_sys);
        end
    endtask

    // one frame in raster order from the frame pulse
    task automatic capture_frame(input string name);
        int    n, ex, ey;
        bit    de_exp;
        string tag;
        rgb_t  want;
        n = 0;
        repeat (3) @(negedge clk_sys);  // scanout pipeline may hold older reads
        while (!sdl_frame) begin
            n++;
            if (n > FRAME_CYC + 8) fail_run("timeout waiting for sdl_frame");
            @(negedge clk_sys);
        end
        for (int i = 0; i < FRAME_CYC; i++) begin
            if (i > 0) @(negedge clk_sys);
            ex     = i % `GFX_H_TOTAL;
            ey     = i / `GFX_H_TOTAL;
            de_exp = (ex < `GFX_H_ACTIVE) && (ey < `GFX_V_ACTIVE);
            want   = de_exp ? expected_rgb(ex, ey) : '0;  // black in blanking
            tag    = $sformatf("%s (%0d,%0d)", name, ex, ey);
            check_value({tag, " position"}, {16'd0, 8'(ex), 8'(ey)},
                        {16'd0, sdl_sx, sdl_sy});
            check_value({tag, " de"}, {31'd0, de_exp}, {31'd0, sdl_de});
            check_value({tag, " frame"}, {31'd0, i == 0}, {31'd0, sdl_frame});
            check_value({tag, " rgb"}, {8'd0, want}, {8'd0, sdl_r, sdl_g, sdl_b});
        end
    endtask

    initial begin
        int seed_init;
        int gap;
        seed_init    = $urandom(32'h4bdc);
        rst_sys      = 1'b1;
        cmd          = '0;
        cmd_valid    = 1'b0;
        accepted     = 0;
        total_sent   = 0;
        max_busy     = 0;
        stall_cycles = 0;
        build_table();
        reset_ref_fb();
        repeat (5) @(posedge clk_sys);
        rst_sys <= 1'b0;

        for (int s = 0; s < NSTEPS; s++) begin
            @(negedge clk_sys);
            check_value({step_name[s], " cmd_ready"}, 32'd1, {31'd0, cmd_ready});
            check_value({step_name[s], " idle"}, 32'd1, {31'd0, idle});
            max_busy     = 0;
            stall_cycles = 0;
            @(posedge clk_sys);
            for (int c = 0; c < step_len[s]; c++) begin
                gap = (step_gap_max[s] > 0) ? int'($urandom % (step_gap_max[s] + 1)) : 0;
                send_cmd(step_cmd[s][c], gap);
                apply_to_model(step_cmd[s][c]);
                total_sent++;
            end
            cmd_valid <= 1'b0;
            wait_idle();
            capture_frame(step_name[s]);
            check_value({step_name[s], " accepted"}, total_sent, accepted);
            if (step_min_busy[s] > 0)
                check_value({step_name[s], " parallel lanes"}, 32'd1,
                            {31'd0, max_busy >= step_min_busy[s]});
            if (step_stall[s])
                check_value({step_name[s], " back-pressure"}, 32'd1,
                            {31'd0, stall_cycles > 0});
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/gfx_raster_top.sv */
//**************************************************
// raster top: dispatch, fill lanes, merger, memory,
// display timing and palette scanout
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module gfx_raster_top import gfx_pkg::*; (
    input  logic                          clk_sys,
    input  logic                          rst_sys,
    input  draw_cmd_t                     cmd,
    input  logic                          cmd_valid,
    output logic                          cmd_ready,
    output logic                          idle,
    output logic signed [`GFX_CORD_W-1:0] sdl_sx,
    output logic signed [`GFX_CORD_W-1:0] sdl_sy,
    output logic                          sdl_de,
    output logic                          sdl_frame,
    output logic [7:0]                    sdl_r,
    output logic [7:0]                    sdl_g,
    output logic [7:0]                    sdl_b
);

    draw_cmd_t              lane_cmd [`GFX_LANES];
    logic [`GFX_LANES-1:0]  lane_start, lane_busy;
    pix_wr_t                lane_wr [`GFX_LANES];
    logic [`GFX_LANES-1:0]  lane_wr_valid, credit_ret;
    logic                   merge_empty, fb_we;
    pix_wr_t                fb_wr;
    logic [`GFX_ADDR_W-1:0] rd_addr;
    logic [`GFX_CIDX_W-1:0] rd_cidx;
    scan_pos_t              pos, out_pos;
    rgb_t                   rgb;

    cmd_dispatch u_cmd_dispatch (
        .clk_sys, .rst_sys, .cmd, .cmd_valid, .cmd_ready,
        .lane_busy, .lane_cmd, .lane_start, .merge_empty, .idle
    );

    for (genvar i = 0; i < `GFX_LANES; i++) begin : g_lane
        rect_fill_engine u_rect_fill_engine (
            .clk_sys, .rst_sys,
            .cmd        (lane_cmd[i]),
            .start      (lane_start[i]),
            .busy       (lane_busy[i]),
            .wr         (lane_wr[i]),
            .wr_valid   (lane_wr_valid[i]),
            .credit_ret (credit_ret[i])
        );
    end

    pixel_write_merge u_pixel_write_merge (
        .clk_sys, .rst_sys, .wr(lane_wr), .wr_valid(lane_wr_valid),
        .credit_ret, .fb_wr, .fb_we, .empty(merge_empty)
    );

    framebuffer_ram u_framebuffer_ram (
        .clk_sys, .we(fb_we), .wr(fb_wr), .rd_addr, .rd_cidx
    );

    display_timing u_display_timing (.clk_sys, .rst_sys, .pos);

    scanout_palette u_scanout_palette (
        .clk_sys, .rst_sys, .pos, .rd_addr, .rd_cidx, .out_pos, .rgb
    );

    // sdl style outputs
    assign sdl_sx    = out_pos.sx;
    assign sdl_sy    = out_pos.sy;
    assign sdl_de    = out_pos.de;
    assign sdl_frame = out_pos.frame;
    assign sdl_r     = rgb.r;
    assign sdl_g     = rgb.g;
    assign sdl_b     = rgb.b;

endmodule

`default_nettype wire

/* hw/scanout_palette.sv */
//**************************************************
// scanout: scaled read address, latency alignment,
// palette lookup and black border, registered out
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module scanout_palette import gfx_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_sys,
    input  scan_pos_t              pos,
    output logic [`GFX_ADDR_W-1:0] rd_addr,
    input  logic [`GFX_CIDX_W-1:0] rd_cidx,
    output scan_pos_t              out_pos,
    output rgb_t                   rgb
);

    localparam int SW = (`GFX_SCALE > 1) ? $clog2(`GFX_SCALE) : 1;

    logic [`GFX_CORD_W-1:0] fx;        // framebuffer column
    logic [SW-1:0]          xs, ys;    // position inside scaled pixel
    logic [`GFX_ADDR_W-1:0] row_base;  // fy * FB_W, stepped per scaled row
    logic                   line_end, next_top, paint;
    scan_pos_t              pos_d [2];
    logic [1:0]             paint_d;

    assign line_end = (pos.sx == `GFX_H_TOTAL - 1);
    assign next_top = (`GFX_OFFY == 0) ? (pos.sy == `GFX_V_TOTAL - 1)
                                       : (pos.sy == `GFX_OFFY - 1);
    assign paint = (pos.sy >= `GFX_OFFY) && (pos.sy < `GFX_OFFY + `GFX_FB_H * `GFX_SCALE)
                && (pos.sx >= 0) && (pos.sx < `GFX_FB_W * `GFX_SCALE);

    // counters track the current position, no divide
    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            fx       <= '0;
            xs       <= '0;
            ys       <= '0;
            row_base <= '0;
        end else begin
            if (line_end) begin
                fx <= '0;
                xs <= '0;
            end else if (xs == SW'(`GFX_SCALE - 1)) begin
                xs <= '0;
                fx <= fx + 1'b1;
            end else begin
                xs <= xs + 1'b1;
            end
            if (line_end) begin
                if (next_top) begin      // picture starts next line
                    ys       <= '0;
                    row_base <= '0;
                end else if (ys == SW'(`GFX_SCALE - 1)) begin
                    ys       <= '0;
                    row_base <= row_base + `GFX_ADDR_W'(`GFX_FB_W);
                end else begin
                    ys <= ys + 1'b1;
                end
            end
        end
    end

    // stage 1 address, stage 2 memory, stage 3 palette
    always_ff @(posedge clk_sys) begin
        rd_addr <= row_base + `GFX_ADDR_W'(fx);
        rgb     <= (pos_d[1].de && paint_d[1]) ? palette_rgb(rd_cidx) : '0;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pos_d[0] <= '0;
            pos_d[1] <= '0;
            paint_d  <= '0;
            out_pos  <= '0;
        end else begin
            pos_d[0] <= pos;
            pos_d[1] <= pos_d[0];
            paint_d  <= {paint_d[0], paint};
            out_pos  <= pos_d[1];  // lines up with rgb
        end
    end

endmodule

`default_nettype wire

/* hw/display_timing.sv */
//**************************************************
// display timing: line and frame counters, data
// enable, frame and line pulses
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module display_timing import gfx_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    output scan_pos_t pos
);

    logic signed [`GFX_CORD_W-1:0] sx, sy;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            sx <= '0;
            sy <= '0;
        end else if (sx == `GFX_H_TOTAL - 1) begin  // end of line
            sx <= '0;
            sy <= (sy == `GFX_V_TOTAL - 1) ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // no blanking offset, active area starts at (0,0)
    always_comb begin
        pos.sx    = sx;
        pos.sy    = sy;
        pos.de    = (sx < `GFX_H_ACTIVE) && (sy < `GFX_V_ACTIVE);
        pos.frame = (sx == 0) && (sy == 0);
        pos.line  = (sx == 0);
    end

endmodule

`default_nettype wire

/* hw/framebuffer_ram.sv */
//**************************************************
// framebuffer memory, one write port and one
// registered read port
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module framebuffer_ram import gfx_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   we,
    input  pix_wr_t                wr,
    input  logic [`GFX_ADDR_W-1:0] rd_addr,
    output logic [`GFX_CIDX_W-1:0] rd_cidx
);

    localparam int DEPTH = `GFX_FB_W * `GFX_FB_H;

    logic [`GFX_CIDX_W-1:0] mem [DEPTH];

    initial begin
        for (int i = 0; i < DEPTH; i++) mem[i] = '0;  // starts as palette 0
    end

    always_ff @(posedge clk_sys) begin
        if (we) mem[wr.addr] <= wr.cidx;
        rd_cidx <= mem[rd_addr];  // one cycle read
    end

endmodule

`default_nettype wire

/* hw/pixel_write_merge.sv */
//**************************************************
// write merger: per-lane fifos, credit return and
// round-robin drain onto the framebuffer write port
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module pixel_write_merge import gfx_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst_sys,
    input  pix_wr_t               wr [`GFX_LANES],
    input  logic [`GFX_LANES-1:0] wr_valid,
    output logic [`GFX_LANES-1:0] credit_ret,
    output pix_wr_t               fb_wr,
    output logic                  fb_we,
    output logic                  empty
);

    localparam int LW  = (`GFX_LANES > 1) ? $clog2(`GFX_LANES) : 1;
    localparam int PW  = (`GFX_CREDITS > 1) ? $clog2(`GFX_CREDITS) : 1;
    localparam int CNW = $clog2(`GFX_CREDITS + 1);

    pix_wr_t               fifo_mem [`GFX_LANES][`GFX_CREDITS];
    logic [PW-1:0]         wp [`GFX_LANES];
    logic [PW-1:0]         rp [`GFX_LANES];
    logic [CNW-1:0]        cnt [`GFX_LANES];
    logic [LW-1:0]         rr;       // first lane to look at
    logic [LW-1:0]         grant;
    logic                  grant_ok;
    logic [`GFX_LANES-1:0] pop;
    logic                  all_empty;

    // round robin from rr, nearest non-empty fifo wins
    always_comb begin
        int idx;
        grant    = rr;
        grant_ok = 1'b0;
        for (int k = `GFX_LANES - 1; k >= 0; k--) begin
            idx = int'(rr) + k;
            if (idx >= `GFX_LANES) idx -= `GFX_LANES;
            if (cnt[idx] != '0) begin
                grant    = LW'(idx);
                grant_ok = 1'b1;
            end
        end
    end

    always_comb begin
        all_empty = 1'b1;
        for (int i = 0; i < `GFX_LANES; i++) begin
            pop[i] = grant_ok && (grant == LW'(i));
            if (cnt[i] != '0) all_empty = 1'b0;
        end
    end

    assign empty = all_empty && !fb_we;  // include write still in flight

    always_ff @(posedge clk_sys) begin
        for (int i = 0; i < `GFX_LANES; i++) begin
            if (wr_valid[i]) fifo_mem[i][wp[i]] <= wr[i];
        end
        fb_wr <= fifo_mem[grant][rp[grant]];
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            rr         <= '0;
            fb_we      <= 1'b0;
            credit_ret <= '0;
            for (int i = 0; i < `GFX_LANES; i++) begin
                wp[i]  <= '0;
                rp[i]  <= '0;
                cnt[i] <= '0;
            end
        end else begin
            fb_we      <= grant_ok;
            credit_ret <= pop;       // credit back with the pop
            if (grant_ok) rr <= (grant == LW'(`GFX_LANES - 1)) ? '0 : grant + 1'b1;
            for (int i = 0; i < `GFX_LANES; i++) begin
                if (wr_valid[i]) wp[i] <= (wp[i] == PW'(`GFX_CREDITS - 1)) ? '0 : wp[i] + 1'b1;
                if (pop[i])      rp[i] <= (rp[i] == PW'(`GFX_CREDITS - 1)) ? '0 : rp[i] + 1'b1;
                cnt[i] <= cnt[i] + CNW'(wr_valid[i]) - CNW'(pop[i]);
            end
        end
    end

    // engine credits should make overflow impossible
    for (genvar i = 0; i < `GFX_LANES; i++) begin : g_chk
        a_no_overflow: assert property (@(posedge clk_sys) disable iff (rst_sys)
            wr_valid[i] |-> cnt[i] < CNW'(`GFX_CREDITS))
            else $error("lane %0d fifo pushed while full", i);
    end

endmodule

`default_nettype wire

/* hw/rect_fill_engine.sv */
//**************************************************
// rectangle fill lane: clip to framebuffer, walk rows
// and emit pixel writes while credits last
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module rect_fill_engine import gfx_pkg::*; (
    input  logic      clk_sys,
    input  logic      rst_sys,
    input  draw_cmd_t cmd,
    input  logic      start,
    output logic      busy,
    output pix_wr_t   wr,
    output logic      wr_valid,
    input  logic      credit_ret
);

    localparam int CRW = $clog2(`GFX_CREDITS + 1);
    localparam int EW  = `GFX_CORD_W + 2;  // room for x0+w

    fill_state_e             state;
    draw_cmd_t               cmd_r;
    logic [CRW-1:0]          credits;
    logic signed [EW-1:0]    x_beg, x_end, y_beg, y_end;
    logic                    empty;
    logic [`GFX_ADDR_W-1:0]  start_addr;
    logic [`GFX_CORD_W-1:0]  x_lo, x_hi, y_hi, x_cur, y_cur;
    logic [`GFX_ADDR_W-1:0]  addr, row_addr;

    // clip window used in CLIP
    always_comb begin
        x_beg = (cmd_r.x0 < 0) ? '0 : EW'(cmd_r.x0);
        y_beg = (cmd_r.y0 < 0) ? '0 : EW'(cmd_r.y0);
        x_end = cmd_r.x0 + $signed({2'b00, cmd_r.w}) - 1;  // inclusive
        y_end = cmd_r.y0 + $signed({2'b00, cmd_r.h}) - 1;
        if (x_end > `GFX_FB_W - 1) x_end = `GFX_FB_W - 1;
        if (y_end > `GFX_FB_H - 1) y_end = `GFX_FB_H - 1;
        empty = (x_beg > x_end) || (y_beg > y_end);  // zero size lands here too
        start_addr = `GFX_ADDR_W'(y_beg * `GFX_FB_W + x_beg);
    end

    assign busy     = (state != IDLE);
    assign wr_valid = (state == ROW) && (credits != '0);
    assign wr.addr  = addr;
    assign wr.cidx  = cmd_r.cidx;

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            state   <= IDLE;
            credits <= CRW'(`GFX_CREDITS);
        end else begin
            credits <= credits - CRW'(wr_valid) + CRW'(credit_ret);
            case (state)
                IDLE: if (start) state <= CLIP;
                CLIP: state <= empty ? IDLE : ROW;
                ROW:  if (wr_valid && x_cur == x_hi && y_cur == y_hi) state <= DONE;
                DONE: state <= IDLE;  // last write already pushed
                default: state <= IDLE;
            endcase
        end
    end

    // walk datapath
    always_ff @(posedge clk_sys) begin
        if (state == IDLE && start) cmd_r <= cmd;
        if (state == CLIP) begin
            x_lo     <= x_beg[`GFX_CORD_W-1:0];
            x_hi     <= x_end[`GFX_CORD_W-1:0];
            y_hi     <= y_end[`GFX_CORD_W-1:0];
            x_cur    <= x_beg[`GFX_CORD_W-1:0];
            y_cur    <= y_beg[`GFX_CORD_W-1:0];
            addr     <= start_addr;
            row_addr <= start_addr;
        end else if (wr_valid) begin
            if (x_cur == x_hi) begin     // next row starts at x_lo
                x_cur    <= x_lo;
                y_cur    <= y_cur + 1'b1;
                row_addr <= row_addr + `GFX_ADDR_W'(`GFX_FB_W);
                addr     <= row_addr + `GFX_ADDR_W'(`GFX_FB_W);
            end else begin
                x_cur <= x_cur + 1'b1;
                addr  <= addr + 1'b1;
            end
        end
    end

    // spending the last credit stops writes until one comes back
    a_no_overdraw: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (credits == CRW'(1)) && wr_valid && !credit_ret |=> !wr_valid)
        else $error("write without credit");

    // merger must not hand back more credits than were spent
    a_credit_max: assert property (@(posedge clk_sys) disable iff (rst_sys)
        credits <= CRW'(`GFX_CREDITS))
        else $error("credit count %0d above limit", credits);

endmodule

`default_nettype wire

/* hw/cmd_dispatch.sv */
//**************************************************
// command dispatch with one-entry holding register,
// free lane pick, clear banding and clear barrier
//**************************************************
`default_nettype none
`timescale 1ns/1ns
`include "gfx_macros.svh"

module cmd_dispatch import gfx_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_sys,
    input  draw_cmd_t              cmd,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic [`GFX_LANES-1:0]  lane_busy,
    output draw_cmd_t              lane_cmd [`GFX_LANES],
    output logic [`GFX_LANES-1:0]  lane_start,
    input  logic                   merge_empty,
    output logic                   idle
);

    draw_cmd_t             pend_cmd;
    logic                  pend_valid;
    logic                  clr_run;    // clear lanes still draining
    logic [`GFX_LANES-1:0] free_hot;   // lowest free lane as one-hot
    logic                  all_quiet;
    logic                  issue;

    // lowest index wins
    always_comb begin
        free_hot = '0;
        for (int i = `GFX_LANES - 1; i >= 0; i--) begin
            if (!lane_busy[i]) free_hot = `GFX_LANES'(1) << i;
        end
    end

    assign all_quiet = (lane_busy == '0) && merge_empty;

    always_comb begin
        issue = 1'b0;
        if (pend_valid && !clr_run) begin
            if (pend_cmd.op == OP_CLEAR) issue = all_quiet;  // barrier
            else                         issue = (free_hot != '0);
        end
    end

    assign lane_start = !issue ? '0 : (pend_cmd.op == OP_CLEAR) ? '1 : free_hot;
    assign cmd_ready  = !pend_valid || issue;  // slot frees as it issues
    assign idle       = !pend_valid && all_quiet;

    // clears become one full-width row band per lane
    always_comb begin
        for (int i = 0; i < `GFX_LANES; i++) begin
            lane_cmd[i] = pend_cmd;
            if (pend_cmd.op == OP_CLEAR) begin
                lane_cmd[i].x0 = '0;
                lane_cmd[i].y0 = `GFX_CORD_W'(i * `GFX_FB_H / `GFX_LANES);
                lane_cmd[i].w  = `GFX_CORD_W'(`GFX_FB_W);
                lane_cmd[i].h  = `GFX_CORD_W'((i + 1) * `GFX_FB_H / `GFX_LANES
                                              - i * `GFX_FB_H / `GFX_LANES);
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (cmd_valid && cmd_ready) pend_cmd <= cmd;  // accepted payload
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pend_valid <= 1'b0;
            clr_run    <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) pend_valid <= 1'b1;
            else if (issue)             pend_valid <= 1'b0;
            if (issue && pend_cmd.op == OP_CLEAR) clr_run <= 1'b1;
            else if (clr_run && all_quiet)         clr_run <= 1'b0;  // bands written
        end
    end

    // the encoder sees a started lane as busy one cycle later
    a_start_taken: assert property (@(posedge clk_sys) disable iff (rst_sys)
        (lane_start != '0) |=> (lane_busy & $past(lane_start)) == $past(lane_start))
        else $error("started lane not busy on the next cycle");

endmodule

`default_nettype wire

/* hw/gfx_pkg.sv */
//**************************************************
// raster types: opcode and fill state enums, command,
// pixel write, scan position, rgb and fixed palette
//**************************************************
`default_nettype none
`include "gfx_macros.svh"

package gfx_pkg;

    typedef enum logic [0:0] {OP_CLEAR, OP_FILL_RECT} gfx_op_e;

    typedef enum logic [1:0] {IDLE, CLIP, ROW, DONE} fill_state_e;

    typedef struct packed {
        gfx_op_e                       op;
        logic signed [`GFX_CORD_W-1:0] x0;   // may start off screen
        logic signed [`GFX_CORD_W-1:0] y0;
        logic [`GFX_CORD_W-1:0]        w;
        logic [`GFX_CORD_W-1:0]        h;
        logic [`GFX_CIDX_W-1:0]        cidx;
    } draw_cmd_t;

    typedef struct packed {
        logic [`GFX_ADDR_W-1:0] addr;
        logic [`GFX_CIDX_W-1:0] cidx;
    } pix_wr_t;

    typedef struct packed {
        logic signed [`GFX_CORD_W-1:0] sx;
        logic signed [`GFX_CORD_W-1:0] sy;
        logic                          de;     // active area
        logic                          frame;  // at (0,0)
        logic                          line;   // at sx 0
    } scan_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    // 4 bits per channel, rrrr_gggg_bbbb
    localparam logic [11:0] PALETTE [16] = '{
        12'h124, 12'hFFF, 12'hE22, 12'h2C3, 12'h23E, 12'hEE3, 12'h2DE, 12'hD3D,
        12'h888, 12'hF82, 12'h741, 12'h8CF, 12'hFAB, 12'h4A6, 12'h527, 12'h000
    };

    function automatic rgb_t palette_rgb(input logic [`GFX_CIDX_W-1:0] cidx);
        logic [11:0] c;
        c = PALETTE[cidx];
        palette_rgb.r = {2{c[11:8]}};  // nibble doubled to 8 bits
        palette_rgb.g = {2{c[7:4]}};
        palette_rgb.b = {2{c[3:0]}};
    endfunction

endpackage

`default_nettype wire

/* include/gfx_macros.svh */
//**************************************************
// sizes for the raster subsystem: framebuffer, display
// mode, fill lanes and merger credits
//**************************************************
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// framebuffer in pixels
`define GFX_FB_W      32
`define GFX_FB_H      24
`define GFX_SCALE     2     // integer upscale on display
`define GFX_OFFY      4     // first display row of picture

// display mode, pixel clock is clk_sys
`define GFX_H_ACTIVE  64
`define GFX_H_TOTAL   80
`define GFX_V_ACTIVE  56
`define GFX_V_TOTAL   60

// drawing
`define GFX_LANES     4     // fill engines, 1..GFX_FB_H
`define GFX_CREDITS   4     // merger fifo depth per lane

// widths
`define GFX_CIDX_W    4     // colour index
`define GFX_ADDR_W    10    // covers FB_W*FB_H
`define GFX_CORD_W    8     // signed coordinates

`endif
